// File: src/kd_wb_pkg.sv
package kd_wb_pkg;

    localparam int DATA_WIDTH = 11;
    localparam int PATCH_SIZE = 5;
    // 26 by 19 query patches
    localparam int NUM_QUERYS = 494;
    localparam int LEAF_SIZE  = 8;
    localparam int NUM_LEAVES = 64;
    localparam int PATCH_W    = DATA_WIDTH * PATCH_SIZE;

    typedef logic [31:0]                     wb_word_t;
    typedef logic [PATCH_W-1:0]              patch_t;
    typedef logic [63:0]                     leaf_word_t;
    typedef logic [$clog2(NUM_QUERYS)-1:0]   qaddr_t;
    typedef logic [$clog2(NUM_LEAVES)-1:0]   leaf_addr_t;
    typedef logic [$clog2(LEAF_SIZE)-1:0]    bank_sel_t;

    localparam wb_word_t ADDR_MASK      = 32'hFFFF_0000;
    localparam wb_word_t MODE_ADDR      = 32'h3000_0000;
    localparam wb_word_t DEBUG_ADDR     = 32'h3000_0004;
    localparam wb_word_t DONE_ADDR      = 32'h3000_0008;
    localparam wb_word_t FSM_START_ADDR = 32'h3000_000C;
    localparam wb_word_t FSM_DONE_ADDR  = 32'h3000_0010;
    localparam wb_word_t LOAD_DONE_ADDR = 32'h3000_0014;
    localparam wb_word_t SEND_DONE_ADDR = 32'h3000_0018;
    localparam wb_word_t CFG_DONE_ADDR  = 32'h3000_001C;
    localparam wb_word_t QUERY_BASE     = 32'h3001_0000;
    localparam wb_word_t LEAF_BASE      = 32'h3002_0000;

    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        logic [3:0] sel;
        wb_word_t   adr;
        wb_word_t   dat;
    } wb_req_t;

    typedef struct packed {
        logic     ack;
        wb_word_t dat;
    } wb_rsp_t;

    typedef struct packed {
        logic   csb;
        logic   web;
        qaddr_t addr;
        patch_t wdata;
    } qmem_port_t;

    // csb and web are active low per bank masks
    typedef struct packed {
        logic [LEAF_SIZE-1:0] csb;
        logic [LEAF_SIZE-1:0] web;
        leaf_addr_t           addr;
        leaf_word_t           wdata;
    } leaf_port_t;

    typedef struct packed {
        logic fsm_done;
        logic load_done;
        logic send_done;
    } acc_done_t;

    typedef struct packed {
        logic mode;
        logic debug;
        logic done;
        logic cfg_done;
        logic fsm_start;
    } ctrl_regs_t;

    typedef enum logic [1:0] {
        Idle,
        ReadMem,
        RegMemRead,
        Ack
    } wbs_state_t;

endpackage

// File: src/kd_wb_top.sv
`timescale 1ns/1ns

module kd_wb_top (
    input  logic                  wb_clk_i,
    input  logic                  wb_rst_i,
    input  kd_wb_pkg::wb_req_t    wb_req_i,
    input  kd_wb_pkg::acc_done_t  acc_done_i,
    output kd_wb_pkg::wb_rsp_t    wb_rsp_o,
    output kd_wb_pkg::ctrl_regs_t ctrl_o
);

    import kd_wb_pkg::*;

    qmem_port_t qmem_port;
    leaf_port_t leaf_port;
    patch_t     qmem_rdata;
    leaf_word_t leaf_rdata;

    wbs_ctrl wbs_ctrl_inst (
        .wb_clk_i     (wb_clk_i),
        .wb_rst_i     (wb_rst_i),
        .wb_req_i     (wb_req_i),
        .acc_done_i   (acc_done_i),
        .qmem_rdata_i (qmem_rdata),
        .leaf_rdata_i (leaf_rdata),
        .wb_rsp_o     (wb_rsp_o),
        .ctrl_o       (ctrl_o),
        .qmem_o       (qmem_port),
        .leaf_o       (leaf_port)
    );

    query_mem query_mem_inst (
        .wb_clk_i (wb_clk_i),
        .port_i   (qmem_port),
        .rdata_o  (qmem_rdata)
    );

    leaf_mem leaf_mem_inst (
        .wb_clk_i (wb_clk_i),
        .port_i   (leaf_port),
        .rdata_o  (leaf_rdata)
    );

endmodule

// File: src/leaf_mem.sv
`timescale 1ns/1ns

module leaf_mem (
    input  logic                  wb_clk_i,
    input  kd_wb_pkg::leaf_port_t port_i,
    output kd_wb_pkg::leaf_word_t rdata_o
);

    import kd_wb_pkg::*;

    leaf_word_t mem [LEAF_SIZE][NUM_LEAVES];
    leaf_word_t bank_rdata [LEAF_SIZE];
    bank_sel_t  rd_bank;
    bank_sel_t  bank_q;
    logic       rd_any;

    // encode the bank being read
    always_comb begin
        rd_bank = '0;
        rd_any  = 1'b0;
        for (int b = 0; b < LEAF_SIZE; b++) begin
            if (!port_i.csb[b] && port_i.web[b]) begin
                rd_bank = bank_sel_t'(b);
                rd_any  = 1'b1;
            end
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (rd_any) begin
            bank_q <= rd_bank;
        end
        for (int b = 0; b < LEAF_SIZE; b++) begin
            if (!port_i.csb[b]) begin
                if (!port_i.web[b]) begin
                    mem[b][port_i.addr] <= port_i.wdata;
                end else begin
                    bank_rdata[b] <= mem[b][port_i.addr];
                end
            end
        end
    end

    assign rdata_o = bank_rdata[bank_q];

endmodule

// File: src/query_mem.sv
`timescale 1ns/1ns

module query_mem (
    input  logic                  wb_clk_i,
    input  kd_wb_pkg::qmem_port_t port_i,
    output kd_wb_pkg::patch_t     rdata_o
);

    import kd_wb_pkg::*;

    patch_t mem [NUM_QUERYS];

    // single port store with a registered read
    always_ff @(posedge wb_clk_i) begin
        if (!port_i.csb) begin
            if (!port_i.web) begin
                mem[port_i.addr] <= port_i.wdata;
            end else begin
                rdata_o <= mem[port_i.addr];
            end
        end
    end

endmodule

// File: src/wbs_ctrl.sv
`timescale 1ns/1ns

module wbs_ctrl (
    input  logic                   wb_clk_i,
    input  logic                   wb_rst_i,
    input  kd_wb_pkg::wb_req_t     wb_req_i,
    input  kd_wb_pkg::acc_done_t   acc_done_i,
    input  kd_wb_pkg::patch_t      qmem_rdata_i,
    input  kd_wb_pkg::leaf_word_t  leaf_rdata_i,
    output kd_wb_pkg::wb_rsp_t     wb_rsp_o,
    output kd_wb_pkg::ctrl_regs_t  ctrl_o,
    output kd_wb_pkg::qmem_port_t  qmem_o,
    output kd_wb_pkg::leaf_port_t  leaf_o
);

    import kd_wb_pkg::*;

    wbs_state_t state_q;
    wbs_state_t state_d;

    wb_req_t    req_q;
    wb_word_t   lower_q;
    logic       accept;
    logic       wr_q;
    logic       ack_q;
    logic       ack_d;
    wb_word_t   dat_q;
    wb_word_t   rd_word;
    logic       dat_en;
    logic       is_query;
    logic       is_leaf;
    bank_sel_t  bank;
    ctrl_regs_t ctrl_q;
    acc_done_t  flags_q;

    assign accept   = (state_q == Idle) && wb_req_i.cyc && wb_req_i.stb;
    assign is_query = (req_q.adr & ADDR_MASK) == QUERY_BASE;
    assign is_leaf  = (req_q.adr & ADDR_MASK) == LEAF_BASE;
    assign bank     = req_q.adr[5:3];

    assign wb_rsp_o.ack = ack_q;
    assign wb_rsp_o.dat = dat_q;
    assign ctrl_o       = ctrl_q;

    always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
        if (wb_rst_i) begin
            state_q <= Idle;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        ack_d   = 1'b0;
        dat_en  = 1'b0;

        qmem_o.csb   = 1'b1;
        qmem_o.web   = 1'b1;
        qmem_o.addr  = req_q.adr[11:3];
        // the high write carries the top 23 bits of the patch
        qmem_o.wdata = {req_q.dat[PATCH_W-33:0], lower_q};

        leaf_o.csb   = '1;
        leaf_o.web   = '1;
        leaf_o.addr  = req_q.adr[11:6];
        leaf_o.wdata = {req_q.dat, lower_q};

        case (state_q)
            Idle: begin
                if (accept) begin
                    state_d = wb_req_i.we ? Ack : ReadMem;
                    ack_d   = wb_req_i.we;
                end
            end
            ReadMem: begin
                state_d = RegMemRead;
                if (is_query) begin
                    qmem_o.csb = 1'b0;
                end else if (is_leaf) begin
                    leaf_o.csb[bank] = 1'b0;
                end
            end
            RegMemRead: begin
                state_d = Ack;
                ack_d   = 1'b1;
                dat_en  = 1'b1;
            end
            Ack: begin
                state_d = Idle;
                // 64-bit word is committed on the write to the upper half
                if (req_q.we && req_q.adr[2]) begin
                    if (is_query) begin
                        qmem_o.csb = 1'b0;
                        qmem_o.web = 1'b0;
                    end else if (is_leaf) begin
                        leaf_o.csb[bank] = 1'b0;
                        leaf_o.web[bank] = 1'b0;
                    end
                end
            end
            default: begin
                state_d = Idle;
            end
        endcase
    end

    // read word from memory data or status flags
    always_comb begin
        rd_word = '0;
        if (is_query) begin
            rd_word = req_q.adr[2] ? wb_word_t'(qmem_rdata_i[PATCH_W-1:32])
                                   : qmem_rdata_i[31:0];
        end else if (is_leaf) begin
            rd_word = req_q.adr[2] ? leaf_rdata_i[63:32] : leaf_rdata_i[31:0];
        end else if (req_q.adr == FSM_DONE_ADDR) begin
            rd_word = {31'd0, flags_q.fsm_done};
        end else if (req_q.adr == LOAD_DONE_ADDR) begin
            rd_word = {31'd0, flags_q.load_done};
        end else if (req_q.adr == SEND_DONE_ADDR) begin
            rd_word = {31'd0, flags_q.send_done};
        end
    end

    always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
        if (wb_rst_i) begin
            req_q <= '0;
            wr_q  <= 1'b0;
        end else begin
            wr_q <= accept && wb_req_i.we;
            if (accept) begin
                req_q <= wb_req_i;
            end
        end
    end

    // data of the previous accepted request is the low half of a 64-bit write
    always_ff @(posedge wb_clk_i) begin
        if (accept) begin
            lower_q <= req_q.dat;
        end
    end

    always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
        if (wb_rst_i) begin
            ack_q <= 1'b0;
            dat_q <= '0;
        end else begin
            ack_q <= ack_d;
            if (dat_en) begin
                dat_q <= rd_word;
            end
        end
    end

    always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
        if (wb_rst_i) begin
            ctrl_q <= '0;
        end else begin
            ctrl_q.fsm_start <= wr_q && (req_q.adr == FSM_START_ADDR);
            if (wr_q) begin
                case (req_q.adr)
                    MODE_ADDR:     ctrl_q.mode     <= req_q.dat[0];
                    DEBUG_ADDR:    ctrl_q.debug    <= req_q.dat[0];
                    DONE_ADDR:     ctrl_q.done     <= req_q.dat[0];
                    CFG_DONE_ADDR: ctrl_q.cfg_done <= req_q.dat[0];
                    default: ;
                endcase
            end
        end
    end

    // a bus write clears a sticky flag ahead of a pulse setting it
    always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
        if (wb_rst_i) begin
            flags_q <= '0;
        end else begin
            if (wr_q && (req_q.adr == FSM_DONE_ADDR)) begin
                flags_q.fsm_done <= 1'b0;
            end else if (acc_done_i.fsm_done) begin
                flags_q.fsm_done <= 1'b1;
            end
            if (wr_q && (req_q.adr == LOAD_DONE_ADDR)) begin
                flags_q.load_done <= 1'b0;
            end else if (acc_done_i.load_done) begin
                flags_q.load_done <= 1'b1;
            end
            if (wr_q && (req_q.adr == SEND_DONE_ADDR)) begin
                flags_q.send_done <= 1'b0;
            end else if (acc_done_i.send_done) begin
                flags_q.send_done <= 1'b1;
            end
        end
    end

endmodule

// File: tests/kd_wb_props.sv
`timescale 1ns/1ns

module kd_wb_props (
    input logic                               wb_clk_i,
    input logic                               wb_rst_i,
    input logic                               ack_i,
    input logic                               fsm_start_i,
    input logic                               qmem_csb_i,
    input logic [kd_wb_pkg::LEAF_SIZE-1:0]    leaf_csb_i,
    input kd_wb_pkg::wbs_state_t              state_i
);

    import kd_wb_pkg::*;

    int unsigned fail_cnt = 0;

    ack_one_cycle: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        ack_i |=> !ack_i)
    else begin
        fail_cnt++;
        $error("ack held longer than one cycle");
    end

    start_one_cycle: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        fsm_start_i |=> !fsm_start_i)
    else begin
        fail_cnt++;
        $error("fsm_start held longer than one cycle");
    end

    // one leaf bank at a time
    leaf_one_bank: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        $onehot0(~leaf_csb_i))
    else begin
        fail_cnt++;
        $error("more than one leaf bank selected");
    end

    csb_in_mem_states: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        (state_i != ReadMem && state_i != Ack) |-> (qmem_csb_i && (&leaf_csb_i)))
    else begin
        fail_cnt++;
        $error("memory selected outside ReadMem and Ack");
    end

endmodule

bind wbs_ctrl kd_wb_props kd_wb_props_inst (
    .wb_clk_i    (wb_clk_i),
    .wb_rst_i    (wb_rst_i),
    .ack_i       (wb_rsp_o.ack),
    .fsm_start_i (ctrl_o.fsm_start),
    .qmem_csb_i  (qmem_o.csb),
    .leaf_csb_i  (leaf_o.csb),
    .state_i     (state_q)
);

// File: tests/kd_wb_tb.sv
`timescale 1ns/1ns

module kd_wb_tb;

    import kd_wb_pkg::*;

    typedef enum {
        OP_WR,
        OP_WR_CTRL,
        OP_START,
        OP_RD,
        OP_PULSE,
        OP_CTRL
    } op_t;

    logic       wb_clk;
    logic       wb_rst;
    wb_req_t    wb_req;
    acc_done_t  acc_done;
    wb_rsp_t    wb_rsp;
    ctrl_regs_t ctrl;

    string      row_name[$];
    op_t        row_op[$];
    wb_word_t   row_adr[$];
    wb_word_t   row_wdat[$];
    wb_word_t   row_exp[$];
    ctrl_regs_t row_ctrl[$];

    int unsigned err_cnt        = 0;
    int unsigned pass_cnt       = 0;
    int unsigned fail_cnt       = 0;
    int unsigned cycle_cnt      = 0;
    int unsigned timeout_cycles = 0;

    tb_clkgen clkgen_inst (
        .wb_clk_o (wb_clk),
        .wb_rst_o (wb_rst)
    );

    kd_wb_top kd_wb_top_inst (
        .wb_clk_i   (wb_clk),
        .wb_rst_i   (wb_rst),
        .wb_req_i   (wb_req),
        .acc_done_i (acc_done),
        .wb_rsp_o   (wb_rsp),
        .ctrl_o     (ctrl)
    );

    always @(posedge wb_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (timeout_cycles != 0 && cycle_cnt >= timeout_cycles) begin
            $display("run timed out after %0d cycles", cycle_cnt);
            $display("*** FAILED ***");
            $finish;
        end
    end

    function automatic wb_word_t query_word_addr(input int idx, input bit hi);
        return QUERY_BASE | wb_word_t'(idx << 3) | (hi ? 32'h4 : 32'h0);
    endfunction

    function automatic wb_word_t leaf_word_addr(input int entry, input int bank, input bit hi);
        return LEAF_BASE | wb_word_t'(entry << 6) | wb_word_t'(bank << 3) | (hi ? 32'h4 : 32'h0);
    endfunction

    function automatic wb_word_t rand_with_bit0(input bit b);
        wb_word_t w;
        w    = $urandom;
        w[0] = b;
        return w;
    endfunction

    task automatic add_row(input string name, input op_t op, input wb_word_t adr,
                           input wb_word_t wdat, input wb_word_t exp, input ctrl_regs_t c);
        row_name.push_back(name);
        row_op.push_back(op);
        row_adr.push_back(adr);
        row_wdat.push_back(wdat);
        row_exp.push_back(exp);
        row_ctrl.push_back(c);
    endtask

    // called on a falling edge and returns on the falling edge after the idle cycle
    task automatic bus_write(input wb_word_t adr, input wb_word_t dat);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = 1'b1;
        wb_req.sel = 4'hF;
        wb_req.adr = adr;
        wb_req.dat = dat;
        @(negedge wb_clk);
        while (!wb_rsp.ack) @(negedge wb_clk);
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
        wb_req.we  = 1'b0;
        @(negedge wb_clk);
    endtask

    task automatic bus_read(input wb_word_t adr, output wb_word_t dat);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = 1'b0;
        wb_req.sel = 4'hF;
        wb_req.adr = adr;
        @(negedge wb_clk);
        while (!wb_rsp.ack) @(negedge wb_clk);
        dat        = wb_rsp.dat;
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
        @(negedge wb_clk);
    endtask

    task automatic pulse_done(input acc_done_t p);
        acc_done = p;
        @(negedge wb_clk);
        acc_done = '0;
    endtask

    task automatic check_word(input string name, input wb_word_t exp, input wb_word_t act);
        if (act !== exp) begin
            $display("[ERROR] %s expected %h actual %h", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_ctrl(input string name, input ctrl_regs_t exp, input ctrl_regs_t act);
        if (act !== exp) begin
            $display("[ERROR] %s expected %b actual %b", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic build_table();
        ctrl_regs_t c;
        string      n;
        wb_word_t   flag_adr [3];
        string      flag_name [3];
        int         q_idx [4];
        wb_word_t   q_lo [4];
        wb_word_t   q_hi [4];
        int         l_entry [5];
        int         l_bank [5];
        int         l_order [5];
        wb_word_t   l_lo [5];
        wb_word_t   l_hi [5];
        int         k;
        c         = '0;
        flag_adr  = '{FSM_DONE_ADDR, LOAD_DONE_ADDR, SEND_DONE_ADDR};
        flag_name = '{"fsm_done", "load_done", "send_done"};
        q_idx     = '{0, 1, 137, 493};
        l_entry   = '{0, 5, 5, 63, 6};
        l_bank    = '{0, 3, 4, 7, 3};
        l_order   = '{2, 0, 4, 1, 3};

        add_row("reset_ctrl", OP_CTRL, '0, '0, '0, c);
        for (int f = 0; f < 3; f++) begin
            add_row({"reset_", flag_name[f]}, OP_RD, flag_adr[f], '0, '0, c);
        end

        // level registers take data bit 0 and are set first then cleared
        for (int v = 1; v >= 0; v--) begin
            c.mode = v[0];
            n = $sformatf("mode_wr%0d", v);
            add_row(n, OP_WR_CTRL, MODE_ADDR, rand_with_bit0(v[0]), '0, c);
            c.debug = v[0];
            n = $sformatf("debug_wr%0d", v);
            add_row(n, OP_WR_CTRL, DEBUG_ADDR, rand_with_bit0(v[0]), '0, c);
            c.done = v[0];
            n = $sformatf("done_wr%0d", v);
            add_row(n, OP_WR_CTRL, DONE_ADDR, rand_with_bit0(v[0]), '0, c);
            c.cfg_done = v[0];
            n = $sformatf("cfg_done_wr%0d", v);
            add_row(n, OP_WR_CTRL, CFG_DONE_ADDR, rand_with_bit0(v[0]), '0, c);
        end

        add_row("fsm_start", OP_START, FSM_START_ADDR, $urandom, '0, c);

        // fsm_done is the top bit of the pulse vector
        for (int f = 0; f < 3; f++) begin
            add_row({flag_name[f], "_pulse"}, OP_PULSE, '0, 32'h4 >> f, '0, c);
            add_row({flag_name[f], "_set"}, OP_RD, flag_adr[f], '0, 32'd1, c);
            add_row({flag_name[f], "_held"}, OP_RD, flag_adr[f], '0, 32'd1, c);
            add_row({flag_name[f], "_clear"}, OP_WR, flag_adr[f], $urandom, '0, c);
            add_row({flag_name[f], "_cleared"}, OP_RD, flag_adr[f], '0, '0, c);
        end

        for (int i = 0; i < 4; i++) begin
            q_lo[i] = $urandom;
            q_hi[i] = $urandom;
            n = $sformatf("query%0d_wr_lo", q_idx[i]);
            add_row(n, OP_WR, query_word_addr(q_idx[i], 1'b0), q_lo[i], '0, c);
            n = $sformatf("query%0d_wr_hi", q_idx[i]);
            add_row(n, OP_WR, query_word_addr(q_idx[i], 1'b1), q_hi[i], '0, c);
        end
        for (int i = 3; i >= 0; i--) begin
            n = $sformatf("query%0d_rd_lo", q_idx[i]);
            add_row(n, OP_RD, query_word_addr(q_idx[i], 1'b0), '0, q_lo[i], c);
            // a 55-bit patch keeps 23 bits of the high word
            n = $sformatf("query%0d_rd_hi", q_idx[i]);
            add_row(n, OP_RD, query_word_addr(q_idx[i], 1'b1), '0, q_hi[i] & 32'h007F_FFFF, c);
        end

        for (int i = 0; i < 5; i++) begin
            l_lo[i] = $urandom;
            l_hi[i] = $urandom;
            n = $sformatf("leaf_b%0d_e%0d_wr_lo", l_bank[i], l_entry[i]);
            add_row(n, OP_WR, leaf_word_addr(l_entry[i], l_bank[i], 1'b0), l_lo[i], '0, c);
            n = $sformatf("leaf_b%0d_e%0d_wr_hi", l_bank[i], l_entry[i]);
            add_row(n, OP_WR, leaf_word_addr(l_entry[i], l_bank[i], 1'b1), l_hi[i], '0, c);
        end
        for (int j = 0; j < 5; j++) begin
            k = l_order[j];
            n = $sformatf("leaf_b%0d_e%0d_rd_lo", l_bank[k], l_entry[k]);
            add_row(n, OP_RD, leaf_word_addr(l_entry[k], l_bank[k], 1'b0), '0, l_lo[k], c);
            n = $sformatf("leaf_b%0d_e%0d_rd_hi", l_bank[k], l_entry[k]);
            add_row(n, OP_RD, leaf_word_addr(l_entry[k], l_bank[k], 1'b1), '0, l_hi[k], c);
        end

        add_row("unmapped_region", OP_RD, 32'h3003_0008, '0, '0, c);
        add_row("unmapped_reg", OP_RD, 32'h3000_0020, '0, '0, c);
    endtask

    task automatic run_row(input int i);
        ctrl_regs_t exp_c;
        wb_word_t   rdat;
        exp_c = row_ctrl[i];
        case (row_op[i])
            OP_WR: begin
                bus_write(row_adr[i], row_wdat[i]);
            end
            OP_WR_CTRL: begin
                bus_write(row_adr[i], row_wdat[i]);
                check_ctrl(row_name[i], exp_c, ctrl);
            end
            OP_START: begin
                check_ctrl(row_name[i], exp_c, ctrl);
                bus_write(row_adr[i], row_wdat[i]);
                exp_c.fsm_start = 1'b1;
                check_ctrl(row_name[i], exp_c, ctrl);
                @(negedge wb_clk);
                exp_c.fsm_start = 1'b0;
                check_ctrl(row_name[i], exp_c, ctrl);
            end
            OP_RD: begin
                bus_read(row_adr[i], rdat);
                check_word(row_name[i], row_exp[i], rdat);
            end
            OP_PULSE: begin
                pulse_done(acc_done_t'(row_wdat[i][2:0]));
            end
            default: begin
                check_ctrl(row_name[i], exp_c, ctrl);
            end
        endcase
    endtask

    initial begin
        int unsigned errs;
        wb_req   = '0;
        acc_done = '0;
        void'($urandom(32'h117));
        build_table();
        timeout_cycles = 8 * row_name.size() + 100;
        @(negedge wb_rst);
        @(negedge wb_clk);
        for (int i = 0; i < row_name.size(); i++) begin
            errs = err_cnt;
            run_row(i);
            if (err_cnt == errs) begin
                pass_cnt++;
                $display("test %s ok", row_name[i]);
            end else begin
                fail_cnt++;
                $display("test %s failed", row_name[i]);
            end
        end
        if (kd_wb_top_inst.wbs_ctrl_inst.kd_wb_props_inst.fail_cnt != 0) begin
            $display("bus and strobe assertions failed %0d times",
                     kd_wb_top_inst.wbs_ctrl_inst.kd_wb_props_inst.fail_cnt);
            fail_cnt++;
        end
        $display("tests %0d, passed %0d, failed %0d", row_name.size(), pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: tests/tb_clkgen.sv
`timescale 1ns/1ns

module tb_clkgen (
    output logic wb_clk_o,
    output logic wb_rst_o
);

    initial begin
        wb_clk_o = 1'b0;
        forever begin
            #5 wb_clk_o = ~wb_clk_o;
        end
    end

    // reset drops on a falling edge after four rising edges
    initial begin
        wb_rst_o = 1'b1;
        repeat (4) @(posedge wb_clk_o);
        @(negedge wb_clk_o);
        wb_rst_o = 1'b0;
    end

endmodule

// File: vlog.f
src/kd_wb_pkg.sv
src/wbs_ctrl.sv
src/query_mem.sv
src/leaf_mem.sv
src/kd_wb_top.sv
tests/tb_clkgen.sv
tests/kd_wb_props.sv
tests/kd_wb_tb.sv
